//--- common/debug_msg_pkg.sv
package debug_msg_pkg;

    // One ASCII character on the serial line
    typedef logic [7:0] char_t;

    // How a field of the report line is rendered
    typedef enum logic [1:0] {
        FK_FLAG,   // Single bit printed as 0 or 1
        FK_HEX,    // Uppercase hex digits, count set per field
        FK_LABEL   // Literal characters only, used for CR LF
    } field_kind_e;

endpackage

//--- common/debug_status_pkg.sv
package debug_status_pkg;

    // Memory shim state word as the shim exports it
    typedef struct packed {
        logic [1:0] cmd;    // Skid buffer command, 0 none 2 read 3 write
        logic       saved;  // Command parked in the skid buffer
        logic       state;  // Shim FSM state bit
    } shim_state_f_t;

    // Printed whole as M, command field printed again as SC
    typedef union packed {
        logic [3:0]    raw;
        shim_state_f_t f;
    } shim_state_u;

    // SDRAM word address
    typedef logic [28:0] addr_t;

    // Read, write and frame counters
    typedef logic [15:0] count16_t;

    // Active region coordinate, only the low 12 bits get printed
    typedef logic [12:0] coord12_t;

endpackage

//--- common/uart_debug_consts.svh
`ifndef UART_DEBUG_CONSTS_SVH
`define UART_DEBUG_CONSTS_SVH

// System clock of the decoder board
`define UART_DEBUG_CLK_HZ 27000000

// Debug console line rate
`define UART_DEBUG_BAUD 115200

// Integer division, about 234 clocks per bit at 27 MHz
`define UART_DEBUG_CLKS_PER_BIT (`UART_DEBUG_CLK_HZ / `UART_DEBUG_BAUD)

// One report per second
`define UART_DEBUG_REPORT_PERIOD 27000000

// Characters per report line, CR LF included
`define UART_DEBUG_LINE_LEN 85

`endif

//--- report/report_formatter.sv
`timescale 1ns/10ps
`include "uart_debug_consts.svh"

module report_formatter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          snap_valid,
    input  logic                          snap_locked,
    input  logic                          snap_active,
    input  logic                          snap_busy,
    input  logic                          snap_valid_flag,
    input  debug_status_pkg::coord12_t    snap_arx,
    input  debug_status_pkg::coord12_t    snap_ary,
    input  logic [8:0]                    snap_init_cnt,
    input  debug_status_pkg::shim_state_u snap_shim_state,
    input  debug_status_pkg::count16_t    snap_mem_wr_count,
    input  debug_status_pkg::count16_t    snap_mem_rd_count,
    input  debug_status_pkg::addr_t       snap_mem_addr,
    input  logic                          snap_watchdog,
    input  logic [2:0]                    snap_vs_edge_cnt,
    input  debug_status_pkg::count16_t    snap_frame_cnt,
    input  logic                          tx_ready,
    output debug_msg_pkg::char_t          tx_char,
    output logic                          tx_valid,
    output logic                          line_busy
);
    import debug_msg_pkg::*;

    localparam int         LINE_LEN  = `UART_DEBUG_LINE_LEN;
    localparam logic [3:0] LAST_DATA = 4'd14;  // FC, the only field without a trailing space

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_LOAD = 2'd1;
    localparam logic [1:0] S_SEND = 2'd2;

    logic [1:0]  state;
    logic [3:0]  field_idx;
    logic [3:0]  pos;        // Character position inside the current field
    logic [6:0]  char_idx;

    char_t       lab0;
    char_t       lab1;
    field_kind_e kind;
    logic [3:0]  hex_dig;
    logic [31:0] val;
    logic [3:0]  lab_len;
    logic [3:0]  n_dig;
    logic [3:0]  digit_sel;
    logic [3:0]  nibble;
    logic [3:0]  field_len;
    logic        field_end;
    char_t       cur_char;

    function automatic char_t to_hex(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
    endfunction

    // Field table
    always_comb begin
        lab1    = 8'h00;
        kind    = FK_HEX;
        hex_dig = 4'd1;
        val     = '0;
        case (field_idx)
            4'd0:  begin lab0 = "L"; kind = FK_FLAG; val[0] = snap_locked; end
            4'd1:  begin lab0 = "A"; kind = FK_FLAG; val[0] = snap_active; end
            4'd2:  begin lab0 = "B"; kind = FK_FLAG; val[0] = snap_busy; end
            4'd3:  begin lab0 = "V"; kind = FK_FLAG; val[0] = snap_valid_flag; end
            4'd4:  begin lab0 = "X"; hex_dig = 4'd3; val[11:0] = snap_arx[11:0]; end
            4'd5:  begin lab0 = "Y"; hex_dig = 4'd3; val[11:0] = snap_ary[11:0]; end
            4'd6:  begin lab0 = "I"; hex_dig = 4'd3; val[8:0] = snap_init_cnt; end
            4'd7:  begin lab0 = "M"; val[3:0] = snap_shim_state.raw; end
            4'd8:  begin lab0 = "S"; lab1 = "C"; val[1:0] = snap_shim_state.f.cmd; end
            4'd9:  begin lab0 = "W"; hex_dig = 4'd4; val[15:0] = snap_mem_wr_count; end
            4'd10: begin lab0 = "P"; hex_dig = 4'd4; val[15:0] = snap_mem_rd_count; end
            4'd11: begin lab0 = "@"; hex_dig = 4'd8; val[28:0] = snap_mem_addr; end
            4'd12: begin lab0 = "O"; kind = FK_FLAG; val[0] = snap_watchdog; end
            4'd13: begin lab0 = "N"; val[2:0] = snap_vs_edge_cnt; end
            4'd14: begin lab0 = "F"; lab1 = "C"; hex_dig = 4'd4; val[15:0] = snap_frame_cnt; end
            default: begin
                lab0    = 8'h0D;  // CR
                lab1    = 8'h0A;  // LF
                kind    = FK_LABEL;
                hex_dig = 4'd0;
            end
        endcase
    end

    // Character at the current position
    always_comb begin
        lab_len   = (lab1 == 8'h00) ? 4'd1 : 4'd2;
        n_dig     = (kind == FK_FLAG) ? 4'd1 : hex_dig;
        digit_sel = n_dig + lab_len - pos;  // Most significant digit first
        nibble    = 4'(val >> {digit_sel, 2'b00});
        if (kind == FK_LABEL)
            field_len = lab_len;
        else
            field_len = lab_len + n_dig + ((field_idx == LAST_DATA) ? 4'd1 : 4'd2);
        field_end = (pos == field_len - 4'd1);

        if (pos < lab_len)
            cur_char = (pos == 4'd0) ? lab0 : lab1;
        else if (pos == lab_len)
            cur_char = ":";
        else if (pos <= lab_len + n_dig)
            cur_char = (kind == FK_FLAG) ? (val[0] ? "1" : "0") : to_hex(nibble);
        else
            cur_char = " ";
    end

    // Indices only move after a handshake, so the character holds under tx_valid
    assign tx_char = cur_char;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            field_idx <= '0;
            pos       <= '0;
            char_idx  <= '0;
            tx_valid  <= 1'b0;
            line_busy <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (snap_valid) begin
                        field_idx <= '0;
                        pos       <= '0;
                        char_idx  <= '0;
                        line_busy <= 1'b1;
                        state     <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    tx_valid <= 1'b1;
                    state    <= S_SEND;
                end
                S_SEND: begin
                    if (tx_ready) begin
                        tx_valid <= 1'b0;  // Low for a cycle between bytes
                        if (char_idx == 7'(LINE_LEN - 1)) begin
                            line_busy <= 1'b0;
                            state     <= S_IDLE;
                        end else begin
                            char_idx <= char_idx + 7'd1;
                            if (field_end) begin
                                field_idx <= field_idx + 4'd1;
                                pos       <= '0;
                            end else begin
                                pos <= pos + 4'd1;
                            end
                            state <= S_LOAD;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) tx_valid && tx_ready |=> !tx_valid)
        else $error("tx_valid held past an accepted byte");

    assert property (@(posedge clk) disable iff (!rst_n) char_idx < 7'(LINE_LEN))
        else $error("Character index ran past the end of the line");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the UART debug reporter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -f uart_debug.f \
    --top-module tb_uart_debug -Mdir obj_dir -o sim_uart_debug
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_uart_debug)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- tb/tb_uart_debug.sv
`timescale 1ns/10ps
`include "uart_debug_consts.svh"

module tb_uart_debug;
    import debug_status_pkg::*;
    import debug_msg_pkg::*;

    localparam int REPORT_PERIOD = 4000;
    localparam int CLKS_PER_BIT  = 4;
    localparam int LINE_TIMEOUT  = 3 * REPORT_PERIOD;  // Cycles
    localparam int CHAR_TIMEOUT  = 20 * CLKS_PER_BIT;

    logic        clk;
    logic        rst_n;
    logic        locked;
    logic        active;
    logic        busy;
    logic        valid;
    coord12_t    arx;
    coord12_t    ary;
    logic [8:0]  init_cnt;
    shim_state_u shim_state;
    count16_t    mem_wr_count;
    count16_t    mem_rd_count;
    addr_t       mem_addr;
    logic        watchdog_rst;
    logic [2:0]  core_vs_edge_cnt;
    count16_t    core_frame_cnt;
    logic        tx_pin;

    string exp_q[$];
    string name_q[$];
    string got_q[$];
    logic  wd_exp;           // Watchdog flag the next line should carry
    int    lines_pushed  = 0;
    int    lines_started = 0;
    int    lines_done    = 0;
    int    lines_checked = 0;
    int    errors        = 0;
    int    tests_run     = 0;
    int    tests_failed  = 0;

    uart_debug_top #(
        .REPORT_PERIOD(REPORT_PERIOD),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected report line, fields rendered per the line format
    function automatic string ref_line(input logic lk, input logic ac, input logic bz,
                                       input logic vl, input logic [11:0] x,
                                       input logic [11:0] y, input logic [8:0] ic,
                                       input logic [3:0] ss, input logic [15:0] wr,
                                       input logic [15:0] rd, input logic [28:0] ad,
                                       input logic wd, input logic [2:0] vs,
                                       input logic [15:0] fc);
        string s;
        s = $sformatf("L:%b A:%b B:%b V:%b X:%h Y:%h I:%h M:%h SC:%h W:%h P:%h @:%h O:%b N:%h FC:%h",
                      lk, ac, bz, vl, x, y, ic, ss, ss[3:2], wr, rd, ad, wd, vs, fc);
        return {s.toupper(), "\r\n"};
    endfunction

    // Drop the CR LF so error lines stay on one line
    function automatic string printable(input string s);
        if (s.len() >= 2 && s.getc(s.len() - 1) == 8'h0A)
            return s.substr(0, s.len() - 3);
        return s;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests %0d, failed %0d, lines checked %0d, errors %0d",
                 tests_run, tests_failed, lines_checked, errors);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic set_random_fields();
        locked           = 1'($urandom);
        active           = 1'($urandom);
        busy             = 1'($urandom);
        valid            = 1'($urandom);
        arx              = 13'($urandom);
        ary              = 13'($urandom);
        init_cnt         = 9'($urandom);
        shim_state       = 4'($urandom);
        mem_wr_count     = 16'($urandom);
        mem_rd_count     = 16'($urandom);
        mem_addr         = 29'($urandom);
        core_vs_edge_cnt = 3'($urandom);
        core_frame_cnt   = 16'($urandom);
    endtask

    task automatic drive_random();
        @(posedge clk);
        #1;
        set_random_fields();
    endtask

    task automatic expect_line(input string name);
        exp_q.push_back(ref_line(locked, active, busy, valid, arx[11:0], ary[11:0], init_cnt,
                                 shim_state.raw, mem_wr_count, mem_rd_count, mem_addr,
                                 wd_exp, core_vs_edge_cnt, core_frame_cnt));
        name_q.push_back(name);
        lines_pushed++;
        wd_exp = 1'b0;  // Capture clears the latch
    endtask

    task automatic pulse_watchdog();
        @(posedge clk);
        #1 watchdog_rst = 1'b0;
        @(posedge clk);
        #1 watchdog_rst = 1'b1;
        wd_exp = 1'b1;
    endtask

    task automatic wait_line_start();
        int n;
        n = 0;
        while (lines_started < lines_pushed && n < LINE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (lines_started < lines_pushed)
            abort_run("timed out waiting for a report line to start");
    endtask

    task automatic wait_line_done();
        int n;
        n = 0;
        while (lines_done < lines_pushed && n < LINE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (lines_done < lines_pushed)
            abort_run("timed out waiting for a report line to finish");
    endtask

    // Inputs churn while the line is on the wire
    task automatic scramble_until_done();
        int n;
        n = 0;
        while (lines_done < lines_pushed && n < LINE_TIMEOUT) begin
            @(posedge clk);
            n++;
            if (n % 64 == 0) begin
                #1;
                set_random_fields();
            end
        end
        if (lines_done < lines_pushed)
            abort_run("timed out waiting for the scrambled line to finish");
    endtask

    task automatic end_test(input string name, input int err0);
        int n;
        n = 0;
        while (lines_checked < lines_pushed && n < LINE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (lines_checked < lines_pushed)
            abort_run({"decoded lines were never compared in ", name});
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok, %0d lines checked so far", name, lines_checked);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // Serial decoder, samples near the middle of each bit
    initial begin : serial_decoder
        string      line;
        logic [7:0] ch;
        int         n;
        int         limit;
        line = "";
        ch   = '0;
        n    = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1)
            abort_run("reset was never released");
        forever begin
            limit = (line.len() == 0) ? LINE_TIMEOUT : CHAR_TIMEOUT;
            n = 0;
            @(negedge clk);
            while (tx_pin !== 1'b0 && n < limit) begin
                @(negedge clk);
                n++;
            end
            if (tx_pin !== 1'b0)
                abort_run("no start bit on tx_pin before the timeout");
            if (line.len() == 0)
                lines_started++;
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (tx_pin !== 1'b0) begin
                $display("start bit on tx_pin ended early");
                errors++;
            end
            repeat (8) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                ch = {tx_pin, ch[7:1]};  // LSB arrives first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (tx_pin !== 1'b1) begin
                $display("stop bit missing after character %0d of a line", line.len());
                errors++;
            end
            line = $sformatf("%s%c", line, ch);
            if (ch == 8'h0A || line.len() >= `UART_DEBUG_LINE_LEN) begin
                got_q.push_back(line);
                lines_done++;
                line = "";
            end
        end
    end

    initial begin : line_compare
        string got;
        string exp;
        string name;
        int    n;
        forever begin
            n = 0;
            while (got_q.size() == 0 && n < LINE_TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (got_q.size() == 0)
                abort_run("no report line arrived on tx_pin");
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("a line arrived that no test expected: \"%s\"", printable(got));
                errors++;
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                if (got != exp) begin
                    $display("error: %s expected \"%s\" actual \"%s\"",
                             name, printable(exp), printable(got));
                    errors++;
                end
            end
            lines_checked++;
        end
    end

    initial begin : test_sequence
        int err0;
        int i;
        void'($urandom(49372));
        rst_n        = 1'b0;
        watchdog_rst = 1'b1;
        wd_exp       = 1'b0;
        set_random_fields();
        expect_line("idle_after_reset");  // First tick lands right after reset

        err0 = errors;
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            if (tx_pin !== 1'b1) begin
                $display("error: idle_after_reset expected tx_pin 1 actual %b", tx_pin);
                errors++;
            end
        end
        rst_n = 1'b1;
        wait_line_done();
        end_test("idle_after_reset", err0);

        err0 = errors;
        for (i = 0; i < 6; i++) begin
            drive_random();
            expect_line("random_lines");
            wait_line_done();
        end
        end_test("random_lines", err0);

        err0 = errors;
        for (i = 0; i < 2; i++) begin
            drive_random();
            expect_line("snapshot_isolation");
            wait_line_start();  // Snapshot already taken
            scramble_until_done();
        end
        drive_random();
        expect_line("snapshot_isolation");
        wait_line_done();
        end_test("snapshot_isolation", err0);

        err0 = errors;
        drive_random();
        pulse_watchdog();
        expect_line("watchdog_latch");
        wait_line_done();
        drive_random();
        expect_line("watchdog_latch");  // No new pulse
        wait_line_done();
        end_test("watchdog_latch", err0);

        err0 = errors;
        for (i = 0; i < 16; i++) begin
            drive_random();
            shim_state = 4'(i);
            expect_line("shim_decode");
            wait_line_done();
        end
        end_test("shim_decode", err0);

        $display("tests %0d, failed %0d, lines checked %0d, errors %0d",
                 tests_run, tests_failed, lines_checked, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/10ps
`include "uart_debug_consts.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_DEBUG_CLKS_PER_BIT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  debug_msg_pkg::char_t tx_char,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 tx_pin
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;  // 0 is the start bit, 9 the stop bit
    logic [8:0]    shift;    // Data bits then the stop bit, LSB out first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_ready <= 1'b1;
            tx_pin   <= 1'b1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
        end else if (tx_ready) begin
            if (tx_valid) begin
                tx_ready <= 1'b0;
                tx_pin   <= 1'b0;  // Start bit
                clk_cnt  <= '0;
                bit_cnt  <= '0;
            end
        end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_ready <= 1'b1;  // Stop bit done, pin already high
            end else begin
                tx_pin  <= shift[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_ready && tx_valid)
            shift <= {1'b1, tx_char};
        else if (!tx_ready && clk_cnt == CW'(CLKS_PER_BIT - 1) && bit_cnt != 4'd9)
            shift <= {1'b1, shift[8:1]};
    end

    // Idle line is a mark
    assert property (@(posedge clk) disable iff (!rst_n) tx_ready |-> tx_pin)
        else $error("UART ready while the line is not idle");

endmodule

//--- uart_debug.f
+incdir+common
common/debug_status_pkg.sv
common/debug_msg_pkg.sv
verilog/status_sampler.sv
report/report_formatter.sv
uart/uart_tx.sv
verilog/uart_debug_top.sv
tb/tb_uart_debug.sv

//--- verilog/status_sampler.sv
`timescale 1ns/10ps
`include "uart_debug_consts.svh"

module status_sampler #(
    parameter int REPORT_PERIOD = `UART_DEBUG_REPORT_PERIOD
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          locked,
    input  logic                          active,
    input  logic                          busy,
    input  logic                          valid,
    input  debug_status_pkg::coord12_t    arx,
    input  debug_status_pkg::coord12_t    ary,
    input  logic [8:0]                    init_cnt,
    input  debug_status_pkg::shim_state_u shim_state,
    input  debug_status_pkg::count16_t    mem_wr_count,
    input  debug_status_pkg::count16_t    mem_rd_count,
    input  debug_status_pkg::addr_t       mem_addr,
    input  logic                          watchdog_rst,    // Active low pulse
    input  logic [2:0]                    core_vs_edge_cnt,
    input  debug_status_pkg::count16_t    core_frame_cnt,
    input  logic                          line_busy,
    output logic                          snap_valid,
    output logic                          snap_locked,
    output logic                          snap_active,
    output logic                          snap_busy,
    output logic                          snap_valid_flag,
    output debug_status_pkg::coord12_t    snap_arx,
    output debug_status_pkg::coord12_t    snap_ary,
    output logic [8:0]                    snap_init_cnt,
    output debug_status_pkg::shim_state_u snap_shim_state,
    output debug_status_pkg::count16_t    snap_mem_wr_count,
    output debug_status_pkg::count16_t    snap_mem_rd_count,
    output debug_status_pkg::addr_t       snap_mem_addr,
    output logic                          snap_watchdog,
    output logic [2:0]                    snap_vs_edge_cnt,
    output debug_status_pkg::count16_t    snap_frame_cnt
);
    import debug_msg_pkg::*;

    localparam int TW = (REPORT_PERIOD > 1) ? $clog2(REPORT_PERIOD) : 1;

    logic [TW-1:0] timer;
    logic          wd_latch;
    logic          accept;

    // Ticks that land mid-line are dropped, not queued
    assign accept = (timer == '0) && !line_busy && !snap_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer      <= '0;
            wd_latch   <= 1'b0;
            snap_valid <= 1'b0;
        end else begin
            timer      <= (timer == TW'(REPORT_PERIOD - 1)) ? '0 : timer + 1'b1;
            snap_valid <= accept;
            if (accept)
                wd_latch <= !watchdog_rst;  // A pulse right now carries into the next report
            else if (!watchdog_rst)
                wd_latch <= 1'b1;
        end
    end

    // Snapshot holds still while the formatter walks it
    always_ff @(posedge clk) begin
        if (accept) begin
            snap_locked       <= locked;
            snap_active       <= active;
            snap_busy         <= busy;
            snap_valid_flag   <= valid;
            snap_arx          <= arx;
            snap_ary          <= ary;
            snap_init_cnt     <= init_cnt;
            snap_shim_state   <= shim_state;
            snap_mem_wr_count <= mem_wr_count;
            snap_mem_rd_count <= mem_rd_count;
            snap_mem_addr     <= mem_addr;
            snap_watchdog     <= wd_latch | !watchdog_rst;
            snap_vs_edge_cnt  <= core_vs_edge_cnt;
            snap_frame_cnt    <= core_frame_cnt;
        end
    end

    // A new snapshot under a line in flight would tear the printed fields
    assert property (@(posedge clk) disable iff (!rst_n) $rose(snap_valid) |-> !line_busy)
        else $error("Snapshot strobe while line busy, kind %0d fields would tear", FK_HEX);

endmodule

//--- verilog/uart_debug_top.sv
`timescale 1ns/10ps
`include "uart_debug_consts.svh"

module uart_debug_top #(
    parameter int REPORT_PERIOD = `UART_DEBUG_REPORT_PERIOD,
    parameter int CLKS_PER_BIT  = `UART_DEBUG_CLKS_PER_BIT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          locked,
    input  logic                          active,
    input  logic                          busy,
    input  logic                          valid,
    input  debug_status_pkg::coord12_t    arx,
    input  debug_status_pkg::coord12_t    ary,
    input  logic [8:0]                    init_cnt,
    input  debug_status_pkg::shim_state_u shim_state,
    input  debug_status_pkg::count16_t    mem_wr_count,
    input  debug_status_pkg::count16_t    mem_rd_count,
    input  debug_status_pkg::addr_t       mem_addr,
    input  logic                          watchdog_rst,
    input  logic [2:0]                    core_vs_edge_cnt,
    input  debug_status_pkg::count16_t    core_frame_cnt,
    output logic                          tx_pin
);
    import debug_status_pkg::*;
    import debug_msg_pkg::*;

    logic        snap_valid;
    logic        snap_locked;
    logic        snap_active;
    logic        snap_busy;
    logic        snap_valid_flag;
    coord12_t    snap_arx;
    coord12_t    snap_ary;
    logic [8:0]  snap_init_cnt;
    shim_state_u snap_shim_state;
    count16_t    snap_mem_wr_count;
    count16_t    snap_mem_rd_count;
    addr_t       snap_mem_addr;
    logic        snap_watchdog;
    logic [2:0]  snap_vs_edge_cnt;
    count16_t    snap_frame_cnt;
    logic        line_busy;
    char_t       tx_char;
    logic        tx_valid;
    logic        tx_ready;

    status_sampler #(.REPORT_PERIOD(REPORT_PERIOD)) u_sampler (.*);

    // Snapshot to ASCII line
    report_formatter u_formatter (.*);

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (.*);

endmodule
